// File: logic/ex_consts.svh
`ifndef EX_CONSTS_SVH
`define EX_CONSTS_SVH

////////////////////
// Datapath
////////////////////

// Integer register width
`define EX_XLEN 32

////////////////////
// Opcode widths
////////////////////

// ALU operation code
`define EX_ALU_OP_W 5
// Multiply operation code
`define EX_MD_OP_W 2

// Shift-add steps per multiply, one per multiplier bit
`define EX_MUL_ITER 32

`endif

// File: logic/ex_pkg.sv
`default_nettype none

`include "ex_consts.svh"

package ex_pkg;

  ////////////////////
  // ALU operations
  ////////////////////

  typedef enum logic [`EX_ALU_OP_W-1:0] {
    // Arithmetic
    ALU_ADD,
    ALU_SUB,
    // Bitwise logic
    ALU_XOR,
    ALU_OR,
    ALU_AND,
    // Shifts, all through the right shifter
    ALU_SRA,
    ALU_SRL,
    ALU_SLL,
    // Compares, flag only
    ALU_LT,
    ALU_LTU,
    ALU_LE,
    ALU_LEU,
    ALU_GT,
    ALU_GTU,
    ALU_GE,
    ALU_GEU,
    ALU_EQ,
    ALU_NE,
    // Set-less-than style, 0/1 in the result
    ALU_SLT,
    ALU_SLTU,
    ALU_SLET,
    ALU_SLETU
  } alu_op_e;

  ////////////////////
  // Multiply operations
  ////////////////////

  typedef enum logic [`EX_MD_OP_W-1:0] {
    // Plain ALU op, multiplier stays idle
    MD_NONE,
    // Low word of product
    MD_MUL,
    // High word, unsigned x unsigned
    MD_MULHU
  } md_op_e;

endpackage

`default_nettype wire

// File: logic/ex_alu.sv
`timescale 1ns/10ps
`default_nettype none

`include "ex_consts.svh"

module ex_alu (
  input  ex_pkg::alu_op_e       operator_i,
  input  logic [`EX_XLEN-1:0]   operand_a_i,
  input  logic [`EX_XLEN-1:0]   operand_b_i,

  // Adder borrowed by the multiplier
  input  logic [`EX_XLEN:0]     multdiv_operand_a_i,
  input  logic [`EX_XLEN:0]     multdiv_operand_b_i,
  input  logic                  multdiv_en_i,

  output logic [`EX_XLEN-1:0]   adder_result_o,
  output logic [`EX_XLEN+1:0]   adder_result_ext_o,

  output logic [`EX_XLEN-1:0]   result_o,
  output logic                  comparison_result_o,
  output logic                  is_equal_result_o
);

  localparam int shamt_w = $clog2(`EX_XLEN);

  logic [`EX_XLEN-1:0] operand_a_rev;

  // Adder signals
  logic                negate_b;
  logic [`EX_XLEN:0]   adder_a;
  logic [`EX_XLEN:0]   adder_b;
  logic [`EX_XLEN:0]   operand_b_inv;
  logic [`EX_XLEN-1:0] adder_sum;

  // Shifter signals
  logic                shift_left;
  logic                shift_arith;
  logic [shamt_w-1:0]  shift_amt;
  logic [`EX_XLEN-1:0] shift_in;
  logic [`EX_XLEN:0]   shift_in_ext;
  logic [`EX_XLEN-1:0] shift_right_res;
  logic [`EX_XLEN-1:0] shift_left_res;
  logic [`EX_XLEN-1:0] shift_res;

  // Compare signals
  logic                cmp_signed;
  logic                is_equal;
  logic                is_ge;
  logic                cmp_res;

  // Operand a, bit reversed
  for (genvar i = 0; i < `EX_XLEN; i++) begin : gen_rev_a
    assign operand_a_rev[i] = operand_a_i[`EX_XLEN-1-i];
  end

  ////////////////////
  // Adder
  ////////////////////

  // Subtract and every compare run a - b
  always_comb begin
    negate_b = 1'b0;
    unique case (operator_i)
      ex_pkg::ALU_SUB,
      ex_pkg::ALU_EQ,   ex_pkg::ALU_NE,
      ex_pkg::ALU_LT,   ex_pkg::ALU_LTU,
      ex_pkg::ALU_LE,   ex_pkg::ALU_LEU,
      ex_pkg::ALU_GT,   ex_pkg::ALU_GTU,
      ex_pkg::ALU_GE,   ex_pkg::ALU_GEU,
      ex_pkg::ALU_SLT,  ex_pkg::ALU_SLTU,
      ex_pkg::ALU_SLET, ex_pkg::ALU_SLETU: negate_b = 1'b1;
      default: ;
    endcase
  end

  // Bit 0 is the carry-in slot
  // a side always carries 1, so ~b + 1 when negating
  assign operand_b_inv = {operand_b_i, 1'b0} ^ {(`EX_XLEN+1){negate_b}};

  // Multiplier takes over both adder inputs
  assign adder_a = multdiv_en_i ? multdiv_operand_a_i : {operand_a_i, 1'b1};
  assign adder_b = multdiv_en_i ? multdiv_operand_b_i : operand_b_inv;

  assign adder_result_ext_o = {1'b0, adder_a} + {1'b0, adder_b};

  // Drop the carry-in slot
  assign adder_sum      = adder_result_ext_o[`EX_XLEN:1];
  assign adder_result_o = adder_sum;

  ////////////////////
  // Shifter
  ////////////////////

  assign shift_amt   = operand_b_i[shamt_w-1:0];
  assign shift_left  = (operator_i == ex_pkg::ALU_SLL);
  assign shift_arith = (operator_i == ex_pkg::ALU_SRA);

  // Left shift = reverse, shift right, reverse back
  assign shift_in = shift_left ? operand_a_rev : operand_a_i;

  // Extra top bit carries the sign fill for SRA only
  assign shift_in_ext    = {shift_arith & shift_in[`EX_XLEN-1], shift_in};
  assign shift_right_res = `EX_XLEN'($signed(shift_in_ext) >>> shift_amt);

  for (genvar j = 0; j < `EX_XLEN; j++) begin : gen_rev_res
    assign shift_left_res[j] = shift_right_res[`EX_XLEN-1-j];
  end

  assign shift_res = shift_left ? shift_left_res : shift_right_res;

  ////////////////////
  // Comparator
  ////////////////////

  always_comb begin
    cmp_signed = 1'b0;
    unique case (operator_i)
      ex_pkg::ALU_LT,  ex_pkg::ALU_LE,
      ex_pkg::ALU_GT,  ex_pkg::ALU_GE,
      ex_pkg::ALU_SLT, ex_pkg::ALU_SLET: cmp_signed = 1'b1;
      default: ;
    endcase
  end

  // Zero difference means equal
  assign is_equal          = (adder_sum == '0);
  assign is_equal_result_o = is_equal;

  // Same sign bits: difference sign decides
  // Different signs: a's sign bit decides, inverted for signed
  always_comb begin
    if (operand_a_i[`EX_XLEN-1] == operand_b_i[`EX_XLEN-1]) begin
      is_ge = ~adder_sum[`EX_XLEN-1];
    end else begin
      is_ge = operand_a_i[`EX_XLEN-1] ^ cmp_signed;
    end
  end

  always_comb begin
    cmp_res = is_equal;
    unique case (operator_i)
      ex_pkg::ALU_EQ:   cmp_res = is_equal;
      ex_pkg::ALU_NE:   cmp_res = ~is_equal;
      ex_pkg::ALU_GT,
      ex_pkg::ALU_GTU:  cmp_res = is_ge & ~is_equal;
      ex_pkg::ALU_GE,
      ex_pkg::ALU_GEU:  cmp_res = is_ge;
      ex_pkg::ALU_LT,   ex_pkg::ALU_LTU,
      ex_pkg::ALU_SLT,  ex_pkg::ALU_SLTU: cmp_res = ~is_ge;
      ex_pkg::ALU_LE,   ex_pkg::ALU_LEU,
      ex_pkg::ALU_SLET, ex_pkg::ALU_SLETU: cmp_res = ~is_ge | is_equal;
      default: ;
    endcase
  end

  assign comparison_result_o = cmp_res;

  ////////////////////
  // Result mux
  ////////////////////

  always_comb begin
    result_o = '0;
    unique case (operator_i)
      ex_pkg::ALU_AND: result_o = operand_a_i & operand_b_i;
      ex_pkg::ALU_OR:  result_o = operand_a_i | operand_b_i;
      ex_pkg::ALU_XOR: result_o = operand_a_i ^ operand_b_i;

      ex_pkg::ALU_ADD,
      ex_pkg::ALU_SUB: result_o = adder_sum;

      ex_pkg::ALU_SLL,
      ex_pkg::ALU_SRL,
      ex_pkg::ALU_SRA: result_o = shift_res;

      // Flag zero-extended
      ex_pkg::ALU_EQ,   ex_pkg::ALU_NE,
      ex_pkg::ALU_LT,   ex_pkg::ALU_LTU,
      ex_pkg::ALU_LE,   ex_pkg::ALU_LEU,
      ex_pkg::ALU_GT,   ex_pkg::ALU_GTU,
      ex_pkg::ALU_GE,   ex_pkg::ALU_GEU,
      ex_pkg::ALU_SLT,  ex_pkg::ALU_SLTU,
      ex_pkg::ALU_SLET, ex_pkg::ALU_SLETU: result_o = {{(`EX_XLEN-1){1'b0}}, cmp_res};

      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: logic/ex_multdiv_seq.sv
`timescale 1ns/10ps
`default_nettype none

`include "ex_consts.svh"

module ex_multdiv_seq (
  input  logic                 clk_i,
  input  logic                 rst_i,

  // One-cycle launch with operation and operands
  input  logic                 start_i,
  input  ex_pkg::md_op_e       md_op_i,
  input  logic [`EX_XLEN-1:0]  op_a_i,
  input  logic [`EX_XLEN-1:0]  op_b_i,

  // Shared ALU adder
  input  logic [`EX_XLEN+1:0]  adder_result_ext_i,
  output logic                 en_o,
  output logic [`EX_XLEN:0]    alu_operand_a_o,
  output logic [`EX_XLEN:0]    alu_operand_b_o,

  output logic                 done_o,
  output logic [`EX_XLEN-1:0]  result_o
);

  localparam int cnt_w = $clog2(`EX_MUL_ITER);

  typedef enum logic [1:0] {
    MS_IDLE,
    MS_ITER,
    MS_FINISH
  } md_state_e;

  md_state_e           state_q;
  logic [cnt_w-1:0]    cnt_q;

  // Datapath registers
  logic [`EX_XLEN:0]   acc_q;
  logic [`EX_XLEN-1:0] prod_q;
  logic [`EX_XLEN-1:0] mcand_q;
  ex_pkg::md_op_e      op_q;

  logic [`EX_XLEN:0]   sum;
  logic                last_iter;

  ////////////////////
  // Adder hookup
  ////////////////////

  // acc_q holds the unshifted partial sum, so the high half is acc_q >> 1
  // Carry-in slots at bit 0 stay clear
  assign alu_operand_a_o = {acc_q[`EX_XLEN:1], 1'b0};
  assign alu_operand_b_o = prod_q[0] ? {mcand_q, 1'b0} : '0;

  // 33-bit sum with carry out
  assign sum = adder_result_ext_i[`EX_XLEN+1:1];

  assign last_iter = (cnt_q == cnt_w'(`EX_MUL_ITER - 1));

  ////////////////////
  // Control
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= MS_IDLE;
      cnt_q   <= '0;
    end else begin
      unique case (state_q)
        MS_IDLE: begin
          if (start_i) begin
            state_q <= MS_ITER;
            cnt_q   <= '0;
          end
        end
        MS_ITER: begin
          if (last_iter) begin
            state_q <= MS_FINISH;
          end
          cnt_q <= cnt_q + 1'b1;
        end
        // Result visible this cycle only
        MS_FINISH: state_q <= MS_IDLE;
        default:   state_q <= MS_IDLE;
      endcase
    end
  end

  ////////////////////
  // Datapath
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (state_q == MS_IDLE && start_i) begin
      acc_q   <= '0;
      prod_q  <= op_b_i;
      mcand_q <= op_a_i;
      op_q    <= md_op_i;
    end else if (state_q == MS_ITER) begin
      // Keep sum whole, its low bit drops into the product
      acc_q  <= sum;
      prod_q <= {sum[0], prod_q[`EX_XLEN-1:1]};
    end
  end

  assign en_o   = (state_q == MS_ITER);
  assign done_o = (state_q == MS_FINISH);

  // Low word has shifted fully into prod_q
  assign result_o = (op_q == ex_pkg::MD_MULHU) ? acc_q[`EX_XLEN:1] : prod_q;

endmodule

`default_nettype wire

// File: logic/ex_block.sv
`timescale 1ns/10ps
`default_nettype none

`include "ex_consts.svh"

module ex_block (
  input  logic                 clk_i,
  input  logic                 rst_i,

  // Four-phase request side
  input  logic                 req_i,
  input  ex_pkg::alu_op_e      alu_op_i,
  input  ex_pkg::md_op_e       md_op_i,
  input  logic [`EX_XLEN-1:0]  operand_a_i,
  input  logic [`EX_XLEN-1:0]  operand_b_i,

  output logic                 ack_o,
  output logic [`EX_XLEN-1:0]  result_o,
  output logic                 cmp_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ALU,
    ST_MUL,
    ST_ACK
  } ex_state_e;

  ex_state_e           state_q;
  logic                req_q;
  logic                ack_q;
  logic                start_q;
  logic                capture;

  // Captured request
  ex_pkg::alu_op_e     alu_op_q;
  ex_pkg::md_op_e      md_op_q;
  logic [`EX_XLEN-1:0] a_q;
  logic [`EX_XLEN-1:0] b_q;

  // Held response
  logic [`EX_XLEN-1:0] result_q;
  logic                cmp_q;

  // ALU side
  logic [`EX_XLEN-1:0] alu_result;
  logic                alu_cmp;
  logic [`EX_XLEN+1:0] adder_ext;

  // Multiplier side
  logic                md_en;
  logic                md_done;
  logic [`EX_XLEN:0]   md_opa;
  logic [`EX_XLEN:0]   md_opb;
  logic [`EX_XLEN-1:0] md_result;

  ////////////////////
  // Handshake FSM
  ////////////////////

  // Operands are stable while req is up and ack low
  assign capture = (state_q == ST_IDLE) && req_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= ST_IDLE;
      req_q   <= 1'b0;
      ack_q   <= 1'b0;
      start_q <= 1'b0;
    end else begin
      // Sampled request level
      req_q   <= req_i;
      start_q <= 1'b0;
      unique case (state_q)
        ST_IDLE: begin
          if (req_q) begin
            if (md_op_i != ex_pkg::MD_NONE) begin
              state_q <= ST_MUL;
              start_q <= 1'b1;
            end else begin
              state_q <= ST_ALU;
            end
          end
        end
        ST_ALU: begin
          state_q <= ST_ACK;
          ack_q   <= 1'b1;
        end
        ST_MUL: begin
          if (md_done) begin
            state_q <= ST_ACK;
            ack_q   <= 1'b1;
          end
        end
        // Hold while requester keeps req up
        ST_ACK: begin
          if (!req_q) begin
            state_q <= ST_IDLE;
            ack_q   <= 1'b0;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  ////////////////////
  // Payload
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (capture) begin
      alu_op_q <= alu_op_i;
      md_op_q  <= md_op_i;
      a_q      <= operand_a_i;
      b_q      <= operand_b_i;
    end
    if (state_q == ST_ALU) begin
      result_q <= alu_result;
      cmp_q    <= alu_cmp;
    end else if (state_q == ST_MUL && md_done) begin
      // No compare flag for multiplies
      result_q <= md_result;
      cmp_q    <= 1'b0;
    end
  end

  assign ack_o    = ack_q;
  assign result_o = result_q;
  assign cmp_o    = cmp_q;

  ////////////////////
  // Execution units
  ////////////////////

  // Adder is steered to the multiplier while md_en is high
  ex_alu u_alu (
    .operator_i          (alu_op_q),
    .operand_a_i         (a_q),
    .operand_b_i         (b_q),
    .multdiv_operand_a_i (md_opa),
    .multdiv_operand_b_i (md_opb),
    .multdiv_en_i        (md_en),
    .adder_result_o      (),
    .adder_result_ext_o  (adder_ext),
    .result_o            (alu_result),
    .comparison_result_o (alu_cmp),
    .is_equal_result_o   ()
  );

  ex_multdiv_seq u_multdiv (
    .clk_i              (clk_i),
    .rst_i              (rst_i),
    .start_i            (start_q),
    .md_op_i            (md_op_q),
    .op_a_i             (a_q),
    .op_b_i             (b_q),
    .adder_result_ext_i (adder_ext),
    .en_o               (md_en),
    .alu_operand_a_o    (md_opa),
    .alu_operand_b_o    (md_opb),
    .done_o             (md_done),
    .result_o           (md_result)
  );

endmodule

`default_nettype wire

// File: tb/ex_block_asserts.sv
`timescale 1ns/10ps
`default_nettype none

`include "ex_consts.svh"

module ex_block_asserts (
  input logic                    clk_i,
  input logic                    rst_i,
  input logic                    req_i,
  input logic [`EX_ALU_OP_W-1:0] alu_op_i,
  input logic [`EX_MD_OP_W-1:0]  md_op_i,
  input logic [`EX_XLEN-1:0]     operand_a_i,
  input logic [`EX_XLEN-1:0]     operand_b_i,
  input logic                    ack_i
);

  // Ack only ever answers a pending request
  ack_needs_req: assert property (
    @(posedge clk_i) disable iff (rst_i)
    $rose(ack_i) |-> $past(req_i)
  ) else $error("ack_o rose without a request on req_i");

  // Request payload frozen until the ack arrives
  req_payload_stable: assert property (
    @(posedge clk_i) disable iff (rst_i)
    (req_i && !ack_i && $past(req_i) && !$past(ack_i)) |->
      $stable({alu_op_i, md_op_i, operand_a_i, operand_b_i})
  ) else $error("request inputs changed while waiting for ack_o");

  // req low for one sample, ack gone one edge later
  ack_drops_after_req: assert property (
    @(posedge clk_i) disable iff (rst_i)
    ($past(req_i, 3) && !$past(req_i, 2)) |-> !ack_i
  ) else $error("ack_o still high more than one cycle after req_i fell");

endmodule

`default_nettype wire

// File: tb/ex_block_checker.sv
`timescale 1ns/10ps
`default_nettype none

`include "ex_consts.svh"

module ex_block_checker (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                req_i,
  input  ex_pkg::alu_op_e     alu_op_i,
  input  ex_pkg::md_op_e      md_op_i,
  input  logic [`EX_XLEN-1:0] operand_a_i,
  input  logic [`EX_XLEN-1:0] operand_b_i,
  input  logic                ack_i,
  input  logic [`EX_XLEN-1:0] result_i,
  input  logic                cmp_i,
  output int                  err_cnt_o,
  output int                  chk_cnt_o
);

  // Request as seen on its first sample
  ex_pkg::alu_op_e     op_q;
  ex_pkg::md_op_e      md_q;
  logic [`EX_XLEN-1:0] a_q;
  logic [`EX_XLEN-1:0] b_q;
  // Response latched at ack rise
  logic [`EX_XLEN-1:0] held_q;
  logic                held_cmp_q;
  logic                req_prev = 1'b0;
  logic                ack_prev = 1'b0;
  logic                rst_prev = 1'b0;
  logic                pending = 1'b0;
  int                  wait_cnt = 0;

  initial begin
    err_cnt_o = 0;
    chk_cnt_o = 0;
  end

  ////////////////////
  // Reference model
  ////////////////////

  function automatic logic is_compare(input ex_pkg::alu_op_e op);
    return !(op inside {ex_pkg::ALU_ADD, ex_pkg::ALU_SUB, ex_pkg::ALU_XOR, ex_pkg::ALU_OR,
                        ex_pkg::ALU_AND, ex_pkg::ALU_SRA, ex_pkg::ALU_SRL, ex_pkg::ALU_SLL});
  endfunction

  function automatic logic cmp_model(input ex_pkg::alu_op_e op,
                                     input logic [`EX_XLEN-1:0] a, input logic [`EX_XLEN-1:0] b);
    case (op)
      ex_pkg::ALU_LT,  ex_pkg::ALU_SLT:   return $signed(a) < $signed(b);
      ex_pkg::ALU_LTU, ex_pkg::ALU_SLTU:  return a < b;
      ex_pkg::ALU_LE,  ex_pkg::ALU_SLET:  return $signed(a) <= $signed(b);
      ex_pkg::ALU_LEU, ex_pkg::ALU_SLETU: return a <= b;
      ex_pkg::ALU_GT:  return $signed(a) > $signed(b);
      ex_pkg::ALU_GTU: return a > b;
      ex_pkg::ALU_GE:  return $signed(a) >= $signed(b);
      ex_pkg::ALU_GEU: return a >= b;
      ex_pkg::ALU_EQ:  return a == b;
      ex_pkg::ALU_NE:  return a != b;
      default:         return 1'b0;
    endcase
  endfunction

  function automatic logic [`EX_XLEN-1:0] alu_model(input ex_pkg::alu_op_e op,
                                     input logic [`EX_XLEN-1:0] a, input logic [`EX_XLEN-1:0] b);
    logic [4:0] sh;
    sh = b[4:0];
    case (op)
      ex_pkg::ALU_ADD: return a + b;
      ex_pkg::ALU_SUB: return a - b;
      ex_pkg::ALU_XOR: return a ^ b;
      ex_pkg::ALU_OR:  return a | b;
      ex_pkg::ALU_AND: return a & b;
      ex_pkg::ALU_SLL: return a << sh;
      ex_pkg::ALU_SRL: return a >> sh;
      ex_pkg::ALU_SRA: return $signed(a) >>> sh;
      // Compares give the flag as 0/1
      default:         return {{(`EX_XLEN-1){1'b0}}, cmp_model(op, a, b)};
    endcase
  endfunction

  ////////////////////
  // Comparison
  ////////////////////

  task automatic flag_error(input string msg);
    err_cnt_o++;
    $display("ERROR at %0t: %s", $time, msg);
  endtask

  task automatic check_response();
    logic [2*`EX_XLEN-1:0] prod;
    logic [`EX_XLEN-1:0]   exp_res;
    logic                  exp_cmp;
    chk_cnt_o++;
    if (md_q != ex_pkg::MD_NONE) begin
      // Low or high word of the unsigned 64-bit product
      prod = {32'b0, a_q} * {32'b0, b_q};
      exp_res = (md_q == ex_pkg::MD_MUL) ? prod[31:0] : prod[63:32];
      if (result_i !== exp_res) begin
        flag_error($sformatf("%s a=%h b=%h result %h, expected %h",
                             md_q.name(), a_q, b_q, result_i, exp_res));
      end
    end else begin
      exp_res = alu_model(op_q, a_q, b_q);
      if (result_i !== exp_res) begin
        flag_error($sformatf("%s a=%h b=%h result %h, expected %h",
                             op_q.name(), a_q, b_q, result_i, exp_res));
      end
      exp_cmp = cmp_model(op_q, a_q, b_q);
      if (is_compare(op_q) && cmp_i !== exp_cmp) begin
        flag_error($sformatf("%s a=%h b=%h cmp %b, expected %b",
                             op_q.name(), a_q, b_q, cmp_i, exp_cmp));
      end
      // ALU ack is due two edges after the first req sample
      if (wait_cnt != 2) begin
        flag_error($sformatf("%s ack after %0d edges, expected 2", op_q.name(), wait_cnt));
      end
    end
  endtask

  // Sampled at the edge before the DUT registers move
  always @(posedge clk_i) begin
    if (rst_prev && ack_i !== 1'b0) begin
      flag_error("ack_o not low after reset");
    end
    if (rst_i) begin
      pending = 1'b0;
    end else begin
      if (ack_i && !ack_prev) begin
        if (pending) begin
          check_response();
        end else begin
          flag_error("ack_o rose with no request outstanding");
        end
        pending    = 1'b0;
        held_q     = result_i;
        held_cmp_q = cmp_i;
      end else if (ack_i && (result_i !== held_q || cmp_i !== held_cmp_q)) begin
        flag_error($sformatf("result_o/cmp_o moved to %h/%b while ack_o held %h/%b",
                             result_i, cmp_i, held_q, held_cmp_q));
      end
      // New request on rising req
      if (req_i && !req_prev && !ack_i) begin
        op_q     = alu_op_i;
        md_q     = md_op_i;
        a_q      = operand_a_i;
        b_q      = operand_b_i;
        pending  = 1'b1;
        wait_cnt = 0;
      end else if (pending) begin
        wait_cnt++;
      end
    end
    rst_prev = rst_i;
    req_prev = rst_i ? 1'b0 : req_i;
    ack_prev = ack_i;
  end

endmodule

`default_nettype wire

// File: tb/ex_block_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "ex_consts.svh"

module ex_block_tb;

  // Wait limits in cycles
  // Multiply ack lands at 35
  localparam int rise_timeout = 100;
  localparam int fall_timeout = 10;

  logic                clk;
  logic                rst;
  logic                req;
  ex_pkg::alu_op_e     alu_op;
  ex_pkg::md_op_e      md_op;
  logic [`EX_XLEN-1:0] op_a;
  logic [`EX_XLEN-1:0] op_b;
  logic                ack;
  logic [`EX_XLEN-1:0] result;
  logic                cmp;
  int                  err_cnt;
  int                  chk_cnt;
  bit                  timed_out;

  ex_pkg::alu_op_e arith_ops [0:4] = '{ex_pkg::ALU_ADD, ex_pkg::ALU_SUB, ex_pkg::ALU_AND,
                                       ex_pkg::ALU_OR, ex_pkg::ALU_XOR};
  ex_pkg::alu_op_e cmp_ops [0:13] = '{ex_pkg::ALU_LT, ex_pkg::ALU_LTU, ex_pkg::ALU_LE,
                                      ex_pkg::ALU_LEU, ex_pkg::ALU_GT, ex_pkg::ALU_GTU,
                                      ex_pkg::ALU_GE, ex_pkg::ALU_GEU, ex_pkg::ALU_EQ,
                                      ex_pkg::ALU_NE, ex_pkg::ALU_SLT, ex_pkg::ALU_SLTU,
                                      ex_pkg::ALU_SLET, ex_pkg::ALU_SLETU};

  ex_block uut (
    .clk_i (clk), .rst_i (rst), .req_i (req), .alu_op_i (alu_op), .md_op_i (md_op),
    .operand_a_i (op_a), .operand_b_i (op_b), .ack_o (ack), .result_o (result), .cmp_o (cmp)
  );

  ex_block_checker u_checker (
    .clk_i (clk), .rst_i (rst), .req_i (req), .alu_op_i (alu_op), .md_op_i (md_op),
    .operand_a_i (op_a), .operand_b_i (op_b), .ack_i (ack), .result_i (result),
    .cmp_i (cmp), .err_cnt_o (err_cnt), .chk_cnt_o (chk_cnt)
  );

  // Protocol rules on every ex_block
  bind ex_block ex_block_asserts u_asserts (
    .clk_i (clk_i), .rst_i (rst_i), .req_i (req_i), .alu_op_i (alu_op_i),
    .md_op_i (md_op_i), .operand_a_i (operand_a_i), .operand_b_i (operand_b_i), .ack_i (ack_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // Inputs move 1 ns past the edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic apply_reset();
    rst = 1'b1;
    req = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
  endtask

  // Present one request and raise req
  task automatic drive_request(input ex_pkg::alu_op_e op, input ex_pkg::md_op_e md,
                               input logic [`EX_XLEN-1:0] a, input logic [`EX_XLEN-1:0] b);
    alu_op = op;
    md_op  = md;
    op_a   = a;
    op_b   = b;
    req    = 1'b1;
  endtask

  // Wait for ack_o to reach a level
  task automatic wait_ack(input logic level, input int limit, input string what);
    int waited;
    waited = 0;
    while (ack !== level && waited < limit) begin
      next_cycle();
      waited++;
    end
    if (ack !== level) begin
      $display("Timed out after %0d cycles waiting for ack_o to %s", waited, what);
      timed_out = 1'b1;
    end
  endtask

  // One full four-phase transfer
  task automatic do_request(input ex_pkg::alu_op_e op, input ex_pkg::md_op_e md,
                            input logic [`EX_XLEN-1:0] a, input logic [`EX_XLEN-1:0] b);
    int hold;
    drive_request(op, md, a, b);
    wait_ack(1'b1, rise_timeout, "rise");
    if (!timed_out) begin
      // Back-pressure while the operand lines wander
      hold = $urandom_range(0, 5);
      repeat (hold) begin
        next_cycle();
        op_a = $urandom;
        op_b = $urandom;
      end
      req = 1'b0;
      wait_ack(1'b0, fall_timeout, "fall");
    end
  endtask

  task automatic print_test_result(input string name, input int n, input int err_before);
    $display("Test %s: %0d requests, %0d errors", name, n, err_cnt - err_before);
  endtask

  ////////////////////
  // Tests
  ////////////////////

  task automatic arith_logic_test(input int n);
    int err_before;
    err_before = err_cnt;
    for (int i = 0; i < n && !timed_out; i++) begin
      do_request(arith_ops[$urandom_range(0, 4)], ex_pkg::MD_NONE, $urandom, $urandom);
    end
    print_test_result("arith_logic", n, err_before);
  endtask

  task automatic shift_test(input int n);
    int                  err_before;
    ex_pkg::alu_op_e     op;
    logic [`EX_XLEN-1:0] b;
    err_before = err_cnt;
    for (int i = 0; i < n && !timed_out; i++) begin
      case ($urandom_range(0, 2))
        0:       op = ex_pkg::ALU_SLL;
        1:       op = ex_pkg::ALU_SRL;
        default: op = ex_pkg::ALU_SRA;
      endcase
      b = $urandom;
      // Amounts 0 and 31 half the time
      case ($urandom_range(0, 3))
        0:       b[4:0] = 5'd0;
        1:       b[4:0] = 5'd31;
        default: ;
      endcase
      do_request(op, ex_pkg::MD_NONE, $urandom, b);
    end
    print_test_result("shifts", n, err_before);
  endtask

  task automatic compare_test(input int n);
    int                  err_before;
    logic [`EX_XLEN-1:0] a;
    logic [`EX_XLEN-1:0] b;
    err_before = err_cnt;
    for (int i = 0; i < n && !timed_out; i++) begin
      a = $urandom;
      case ($urandom_range(0, 3))
        0:       b = a;
        // Opposite sign bits
        1:       b = {~a[31], 31'($urandom)};
        // Neighbours a-1, a and a+1
        2:       b = a + ($urandom_range(0, 2) - 1);
        default: b = $urandom;
      endcase
      do_request(cmp_ops[$urandom_range(0, 13)], ex_pkg::MD_NONE, a, b);
    end
    print_test_result("compares", n, err_before);
  endtask

  task automatic multiply_test(input int n);
    int                  err_before;
    ex_pkg::md_op_e      md;
    logic [`EX_XLEN-1:0] a;
    logic [`EX_XLEN-1:0] b;
    err_before = err_cnt;
    for (int i = 0; i < n && !timed_out; i++) begin
      md = $urandom_range(0, 1) ? ex_pkg::MD_MULHU : ex_pkg::MD_MUL;
      // All-ones now and then for full carry chains
      a = ($urandom_range(0, 3) == 0) ? '1 : $urandom;
      b = ($urandom_range(0, 3) == 0) ? '1 : $urandom;
      do_request(ex_pkg::ALU_ADD, md, a, b);
    end
    print_test_result("multiplies", n, err_before);
  endtask

  task automatic handshake_test(input int n);
    int             err_before;
    ex_pkg::md_op_e md;
    err_before = err_cnt;
    for (int i = 0; i < n && !timed_out; i++) begin
      // Reset half way through while ack_o is still high
      if (i == n / 2) begin
        drive_request(ex_pkg::ALU_XOR, ex_pkg::MD_NONE, $urandom, $urandom);
        wait_ack(1'b1, rise_timeout, "rise before reset");
        apply_reset();
      end
      md = ($urandom_range(0, 5) == 0) ? ex_pkg::MD_MUL : ex_pkg::MD_NONE;
      do_request(ex_pkg::alu_op_e'($urandom_range(0, 21)), md, $urandom, $urandom);
    end
    print_test_result("handshake", n, err_before);
  endtask

  initial begin
    rst       = 1'b1;
    req       = 1'b0;
    alu_op    = ex_pkg::ALU_ADD;
    md_op     = ex_pkg::MD_NONE;
    op_a      = '0;
    op_b      = '0;
    timed_out = 1'b0;
    void'($urandom(32'h8846_e6a4));
    apply_reset();
    arith_logic_test(40);
    shift_test(40);
    compare_test(60);
    multiply_test(16);
    handshake_test(30);
    $display("Responses checked %0d, errors %0d, timeouts %0d", chk_cnt, err_cnt, timed_out);
    if (!timed_out && err_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
+incdir+logic
logic/ex_pkg.sv
logic/ex_alu.sv
logic/ex_multdiv_seq.sv
logic/ex_block.sv
tb/ex_block_asserts.sv
tb/ex_block_checker.sv
tb/ex_block_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the ex_block testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
  -f all.f --top-module ex_block_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vex_block_tb > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

# Assertion failures show up as Verilator errors
if grep -q "^%Error" sim.log; then
  echo "Errors reported in sim.log"
  exit 1
fi

if grep -q "Simulation finished: FAIL" sim.log; then
  exit 1
fi
exit 0
